// ==== hdl/cpu_pkg.sv ====
// Widths are fixed here at 16-bit data, 16 registers and 16-bit addresses; the types need them.
package cpu_pkg;

	// ====================
	// Widths and registers
	// ====================
	localparam int BITS          = 16;	// Data word width.
	localparam int REGISTER_BITS = 4;	// Register select width.
	localparam int ADDRESS_BITS  = 16;	// Memory and port address width.

	localparam logic [REGISTER_BITS-1:0] LINK_REGISTER           = 4'd15;	// Branch with link.
	localparam logic [REGISTER_BITS-1:0] INTERRUPT_LINK_REGISTER = 4'd14;	// Interrupt return.

	// ====================
	// Opcodes and conditions
	// ====================
	localparam logic [3:0] OP_ALU_SINGLE = 4'd0;	// ALU op on a single register.
	localparam logic [3:0] OP_ALU_REG    = 4'd1;	// ALU op register with register.
	localparam logic [3:0] OP_ALU_IMM    = 4'd2;	// ALU op register with immediate.
	localparam logic [3:0] OP_BRANCH     = 4'd3;
	localparam logic [3:0] OP_BYTE_MEM   = 4'd4;	// Byte load or store.
	localparam logic [3:0] OP_WORD_MEM   = 4'd5;	// Word load or store.
	localparam logic [3:0] OP_PEEK_POKE  = 4'd6;	// Port read or write over APB.
	localparam logic [3:0] OP_INTERRUPT  = 4'd7;
	localparam logic [3:0] OP_COND_MOV   = 4'd8;

	localparam logic [2:0] COND_ALWAYS = 3'd0;
	localparam logic [2:0] COND_Z      = 3'd1;
	localparam logic [2:0] COND_NZ     = 3'd2;
	localparam logic [2:0] COND_C      = 3'd3;
	localparam logic [2:0] COND_NC     = 3'd4;
	localparam logic [2:0] COND_S      = 3'd5;
	localparam logic [2:0] COND_V      = 3'd6;
	localparam logic [2:0] COND_LT     = 3'd7;	// Sign differs from overflow.

	typedef struct packed {
		logic c;
		logic z;
		logic s;
		logic v;
	} cpu_flags_t;

	// ====================
	// Instruction views
	// ====================
	typedef struct packed {
		logic [3:0] opcode;
		logic [3:0] dest;
		logic [3:0] src;
		logic [3:0] operand;
	} reg_fmt_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic       ctl_bit;	// Link, store or poke, by class.
		logic [2:0] cond;
		logic [3:0] dest;
		logic [3:0] aux;
	} ctl_fmt_t;

	typedef union packed {
		reg_fmt_t reg_fmt;
		ctl_fmt_t ctl_fmt;
	} cpu_instr_t;

	typedef struct packed {
		logic                    valid;
		cpu_instr_t              instr;
		logic [BITS-1:0]         alu_out;
		cpu_flags_t              flags;
		logic [ADDRESS_BITS-1:0] addr;
		logic [BITS-1:0]         store_data;
		logic [ADDRESS_BITS-1:0] pc;
	} cpu_issue_t;

	typedef struct packed {
		logic                    valid;
		cpu_instr_t              instr;
		logic [BITS-1:0]         alu_out;
		cpu_flags_t              flags;
		logic [ADDRESS_BITS-1:0] pc;
		logic [BITS-1:0]         memory_in;
		logic [BITS-1:0]         port_in;
		logic [1:0]              memory_wr_mask;
	} cpu_wb_packet_t;

	typedef struct packed {
		logic                     wr_en;
		logic [REGISTER_BITS-1:0] wr_sel;
		logic [BITS-1:0]          wr_data;
	} cpu_reg_write_t;

	typedef struct packed {
		logic                    psel;
		logic                    penable;
		logic                    pwrite;
		logic [ADDRESS_BITS-1:0] paddr;
		logic [BITS-1:0]         pwdata;
	} apb_req_t;

	typedef struct packed {
		logic            pready;
		logic [BITS-1:0] prdata;
	} apb_rsp_t;

endpackage

// ==== hdl/cpu_data_ram.sv ====
// MEM_WORDS must be a power of two, at least 2; contents are undefined until written.
`timescale 1ns/100ps

module cpu_data_ram import cpu_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  logic                         clk,
	input  logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	input  logic [BITS-1:0]              ram_wdata,
	input  logic [1:0]                   ram_be,
	input  logic                         ram_rd,
	output logic [BITS-1:0]              ram_rdata
);

	localparam int HALF = BITS / 2;

	logic [BITS-1:0] mem [MEM_WORDS];

	// ====================
	// Byte-lane write
	// ====================
	always_ff @(posedge clk) begin
		if (ram_be[1]) begin
			mem[ram_addr][BITS-1:HALF] <= ram_wdata[BITS-1:HALF];	// High lane, even byte address.
		end
		if (ram_be[0]) begin
			mem[ram_addr][HALF-1:0] <= ram_wdata[HALF-1:0];	// Low lane, odd byte address.
		end
	end

	// ====================
	// Registered read
	// ====================
	always_ff @(posedge clk) begin
		if (ram_rd) begin
			ram_rdata <= mem[ram_addr];	// Word appears in the cycle after the request.
		end
	end

endmodule

// ==== hdl/cpu_mem_stage.sv ====
// One APB transfer at a time; slot 3 stalls until pready, and RAM depth wraps the word index.
`timescale 1ns/100ps

module cpu_mem_stage import cpu_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_issue_t                   issue,
	output logic                         issue_ready,
	output apb_req_t                     apb_req,
	input  apb_rsp_t                     apb_rsp,
	output logic [$clog2(MEM_WORDS)-1:0] ram_addr,
	output logic [BITS-1:0]              ram_wdata,
	output logic [1:0]                   ram_be,
	output logic                         ram_rd,
	input  logic [BITS-1:0]              ram_rdata,
	output cpu_wb_packet_t               wb_packet
);

	localparam int RAM_AW = $clog2(MEM_WORDS);

	typedef enum logic [1:0] {
		IO_IDLE,
		IO_SETUP,
		IO_ACCESS
	} io_state_t;

	io_state_t      io_state;
	cpu_issue_t     s3;	// Item held in slot 3.
	logic [BITS-1:0] port_in_q;	// Peek data captured on the pready edge.
	cpu_wb_packet_t wb_q;
	cpu_wb_packet_t wb_next;
	logic [3:0]     s3_opcode;
	logic           s3_ctl_bit;
	logic           s3_is_mem;
	logic [1:0]     s3_mask;
	logic           s3_load;
	logic           s3_store;
	logic           accept;
	logic           issue_is_io;

	// ====================
	// Slot-3 decode and RAM
	// ====================
	assign s3_opcode  = s3.instr.ctl_fmt.opcode;
	assign s3_ctl_bit = s3.instr.ctl_fmt.ctl_bit;
	assign s3_is_mem  = (s3_opcode == OP_BYTE_MEM) || (s3_opcode == OP_WORD_MEM);
	assign s3_load    = s3.valid && s3_is_mem && !s3_ctl_bit;
	assign s3_store   = s3.valid && s3_is_mem && s3_ctl_bit;

	always_comb begin
		if (s3_opcode == OP_WORD_MEM) begin
			s3_mask = 2'b11;
		end else if (s3_opcode == OP_BYTE_MEM) begin
			s3_mask = s3.addr[0] ? 2'b01 : 2'b10;	// Even address is the high byte.
		end else begin
			s3_mask = 2'b00;
		end
	end

	assign ram_addr  = s3.addr[1 +: RAM_AW];
	assign ram_wdata = (s3_opcode == OP_BYTE_MEM) ? {2{s3.store_data[7:0]}} : s3.store_data;
	assign ram_be    = s3_store ? s3_mask : 2'b00;
	assign ram_rd    = s3_load;

	// Slot 3 only stalls while an APB transfer is open.
	assign issue_ready = (io_state == IO_IDLE);
	assign accept      = issue.valid && issue_ready;
	assign issue_is_io = (issue.instr.ctl_fmt.opcode == OP_PEEK_POKE);

	always_comb begin
		apb_req.psel    = (io_state != IO_IDLE);
		apb_req.penable = (io_state == IO_ACCESS);
		apb_req.pwrite  = s3_ctl_bit;	// Poke is a write.
		apb_req.paddr   = s3.addr;
		apb_req.pwdata  = s3.store_data;
	end

	// ====================
	// Slot-4 packet
	// ====================
	always_comb begin
		wb_next                = '0;
		wb_next.valid          = issue_ready && s3.valid;	// A stall leaves a bubble behind.
		wb_next.instr          = s3.instr;
		wb_next.alu_out        = s3.alu_out;
		wb_next.flags          = s3.flags;
		wb_next.pc             = s3.pc;
		wb_next.port_in        = port_in_q;
		wb_next.memory_wr_mask = s3_mask;
	end

	always_comb begin
		wb_packet           = wb_q;
		wb_packet.memory_in = ram_rdata;	// RAM word lines up with the packet.
	end

	always_ff @(posedge clk) begin
		if (issue_ready) begin
			s3 <= issue;
		end
		if ((io_state == IO_ACCESS) && apb_rsp.pready) begin
			port_in_q <= apb_rsp.prdata;
		end
		wb_q <= wb_next;
		if (rst) begin
			io_state   <= IO_IDLE;
			s3.valid   <= 1'b0;
			wb_q.valid <= 1'b0;
		end else begin
			case (io_state)
				IO_IDLE: begin
					if (accept && issue_is_io) begin
						io_state <= IO_SETUP;
					end
				end
				IO_SETUP:  io_state <= IO_ACCESS;
				IO_ACCESS: begin
					if (apb_rsp.pready) begin
						io_state <= IO_IDLE;
					end
				end
				default:   io_state <= IO_IDLE;
			endcase
		end
	end

endmodule

// ==== hdl/cpu_writeback.sv ====
// Purely combinational; an invalid packet or a class without a result gives wr_en low.
`timescale 1ns/100ps

module cpu_writeback import cpu_pkg::*; (
	input  cpu_wb_packet_t wb_packet,
	output cpu_reg_write_t reg_write
);

	reg_fmt_t rf;
	ctl_fmt_t cf;

	// Condition test on the flags carried with the packet.
	function automatic logic cond_holds(input logic [2:0] cond, input cpu_flags_t f);
		logic hit;
		case (cond)
			COND_ALWAYS: hit = 1'b1;
			COND_Z:      hit = f.z;
			COND_NZ:     hit = !f.z;
			COND_C:      hit = f.c;
			COND_NC:     hit = !f.c;
			COND_S:      hit = f.s;
			COND_V:      hit = f.v;
			COND_LT:     hit = f.s ^ f.v;
			default:     hit = 1'b0;
		endcase
		return hit;
	endfunction

	assign rf = wb_packet.instr.reg_fmt;	// ALU classes.
	assign cf = wb_packet.instr.ctl_fmt;	// Everything else.

	// ====================
	// Register and value select
	// ====================
	always_comb begin
		reg_write.wr_en   = 1'b0;
		reg_write.wr_sel  = '0;
		reg_write.wr_data = '0;
		case (cf.opcode)
			OP_ALU_SINGLE: begin
				reg_write.wr_en   = 1'b1;
				reg_write.wr_sel  = rf.src;	// Single-register ops write back in place.
				reg_write.wr_data = wb_packet.alu_out;
			end
			OP_ALU_REG, OP_ALU_IMM: begin
				reg_write.wr_en   = 1'b1;
				reg_write.wr_sel  = rf.dest;
				reg_write.wr_data = wb_packet.alu_out;
			end
			OP_BRANCH: begin
				reg_write.wr_en   = cf.ctl_bit;	// Only a linking branch writes.
				reg_write.wr_sel  = LINK_REGISTER;
				reg_write.wr_data = wb_packet.pc;
			end
			OP_BYTE_MEM: begin
				reg_write.wr_en  = !cf.ctl_bit;
				reg_write.wr_sel = cf.dest;
				case (wb_packet.memory_wr_mask)
					2'b10:   reg_write.wr_data = {8'h00, wb_packet.memory_in[15:8]};
					2'b01:   reg_write.wr_data = {8'h00, wb_packet.memory_in[7:0]};
					default: reg_write.wr_data = '0;
				endcase
			end
			OP_WORD_MEM: begin
				reg_write.wr_en   = !cf.ctl_bit;
				reg_write.wr_sel  = cf.dest;
				reg_write.wr_data = wb_packet.memory_in;
			end
			OP_PEEK_POKE: begin
				reg_write.wr_en   = !cf.ctl_bit;	// Peek only.
				reg_write.wr_sel  = cf.dest;
				reg_write.wr_data = wb_packet.port_in;
			end
			OP_INTERRUPT: begin
				reg_write.wr_en   = 1'b1;
				reg_write.wr_sel  = INTERRUPT_LINK_REGISTER;
				reg_write.wr_data = wb_packet.pc;
			end
			OP_COND_MOV: begin
				reg_write.wr_en   = cond_holds(cf.cond, wb_packet.flags);
				reg_write.wr_sel  = cf.dest;
				reg_write.wr_data = wb_packet.alu_out;
			end
			default: ;
		endcase
		if (!wb_packet.valid) begin
			reg_write.wr_en = 1'b0;	// Bubbles never write.
		end
	end

endmodule

// ==== hdl/cpu_register_file.sv ====
// Sixteen registers, one write port and two asynchronous read ports; r0 always reads zero.
`timescale 1ns/100ps

module cpu_register_file import cpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_reg_write_t           reg_write,
	input  logic [REGISTER_BITS-1:0] rd_sel_a,
	output logic [BITS-1:0]          rd_data_a,
	input  logic [REGISTER_BITS-1:0] rd_sel_b,
	output logic [BITS-1:0]          rd_data_b
);

	localparam int NUM_REGS = 1 << REGISTER_BITS;

	logic [BITS-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write.wr_en) begin
			regs[reg_write.wr_sel] <= reg_write.wr_data;	// Writes to r0 are masked on read.
		end
	end

	// ====================
	// Read ports
	// ====================
	assign rd_data_a = (rd_sel_a == '0) ? '0 : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 : regs[rd_sel_b];

endmodule

// ==== hdl/cpu_backend_top.sv ====
// Back end of the pipeline only; the issuer must hold its packet while issue_ready is low.
`timescale 1ns/100ps

module cpu_backend_top import cpu_pkg::*; #(
	parameter int MEM_WORDS = 256
) (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_issue_t               issue,
	output logic                     issue_ready,
	output apb_req_t                 apb_req,
	input  apb_rsp_t                 apb_rsp,
	input  logic [REGISTER_BITS-1:0] rd_sel_a,
	output logic [BITS-1:0]          rd_data_a,
	input  logic [REGISTER_BITS-1:0] rd_sel_b,
	output logic [BITS-1:0]          rd_data_b
);

	logic [$clog2(MEM_WORDS)-1:0] ram_addr;
	logic [BITS-1:0]              ram_wdata;
	logic [1:0]                   ram_be;
	logic                         ram_rd;
	logic [BITS-1:0]              ram_rdata;
	cpu_wb_packet_t               wb_packet;
	cpu_reg_write_t               reg_write;

	cpu_mem_stage #(.MEM_WORDS(MEM_WORDS)) i_mem_stage (
		.clk(clk), .rst(rst),
		.issue(issue), .issue_ready(issue_ready),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be), .ram_rd(ram_rd),
		.ram_rdata(ram_rdata),
		.wb_packet(wb_packet)
	);

	cpu_data_ram #(.MEM_WORDS(MEM_WORDS)) i_data_ram (
		.clk(clk),
		.ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_be(ram_be), .ram_rd(ram_rd),
		.ram_rdata(ram_rdata)
	);

	cpu_writeback i_writeback (
		.wb_packet(wb_packet),
		.reg_write(reg_write)
	);

	cpu_register_file i_register_file (
		.clk(clk), .rst(rst),
		.reg_write(reg_write),
		.rd_sel_a(rd_sel_a), .rd_data_a(rd_data_a),
		.rd_sel_b(rd_sel_b), .rd_data_b(rd_data_b)
	);

endmodule

// ==== dv/tb_cpu_backend.sv ====
// Port addresses are decoded on paddr[3:0] only; loads must target words that were stored first.
`timescale 1ns/100ps

module tb_cpu_backend import cpu_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int MEM_WORDS  = 64;
	localparam int NUM_TESTS  = 5;

	logic                     clk;
	logic                     rst;
	cpu_issue_t               issue;
	logic                     issue_ready;
	apb_req_t                 apb_req;
	apb_rsp_t                 apb_rsp = '0;
	logic [REGISTER_BITS-1:0] rd_sel_a;
	logic [REGISTER_BITS-1:0] rd_sel_b;
	logic [BITS-1:0]          rd_data_a;
	logic [BITS-1:0]          rd_data_b;

	int              errors = 0;
	integer          seed = 29;
	int              wait_left;
	apb_req_t        held;	// Request as seen in the setup cycle.
	apb_req_t        access_exp;
	apb_req_t        captured [$];
	apb_req_t        expected [$];
	logic [BITS-1:0] port_mem [16];	// What the APB completer serves.
	logic [BITS-1:0] port_model [16];	// Port contents as the model predicts them.
	logic [BITS-1:0] reg_model [16];
	logic [BITS-1:0] mem_model [MEM_WORDS];

	cpu_backend_top #(.MEM_WORDS(MEM_WORDS)) i_dut (
		.clk(clk), .rst(rst),
		.issue(issue), .issue_ready(issue_ready),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.rd_sel_a(rd_sel_a), .rd_data_a(rd_data_a),
		.rd_sel_b(rd_sel_b), .rd_data_b(rd_data_b)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(NUM_TESTS * 200 * CLK_PERIOD);
		$display("Watchdog expired at %0t, the DUT stopped making progress", $time);
		$display("Testbench failed");
		$finish;
	end

	// ====================
	// Check tasks
	// ====================
	task automatic check_reg(input logic [REGISTER_BITS-1:0] sel, input logic [BITS-1:0] got,
			input logic [BITS-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: r%0d reads %h, expected %h", $time, sel, got, exp);
		end
	endtask

	task automatic check_apb(input apb_req_t got, input apb_req_t exp, input string what);
		apb_req_t g;
		apb_req_t e;
		g = got;
		e = exp;
		if (!e.pwrite) begin
			g.pwdata = '0;	// Write data means nothing on a read.
			e.pwdata = '0;
		end
		if (g !== e) begin
			errors++;
			$display("Mismatch at %0t: APB %s sel %b en %b wr %b addr %h data %h, expected %b %b %b %h %h",
				$time, what, g.psel, g.penable, g.pwrite, g.paddr, g.pwdata,
				e.psel, e.penable, e.pwrite, e.paddr, e.pwdata);
		end
	endtask

	// ====================
	// APB completer
	// ====================
	always @(posedge clk) begin
		if (rst) begin
			apb_rsp <= '0;
		end else if (apb_req.psel && !apb_req.penable) begin
			held = apb_req;
			captured.push_back(apb_req);
			wait_left = $unsigned($random(seed)) % 4;	// Zero to three wait states.
			apb_rsp.pready <= (wait_left == 0);
			apb_rsp.prdata <= port_mem[apb_req.paddr[3:0]];
		end else if (apb_req.psel && apb_req.penable) begin
			access_exp = held;
			access_exp.penable = 1'b1;
			check_apb(apb_req, access_exp, "access");	// Request must hold steady.
			if (apb_rsp.pready) begin
				if (apb_req.pwrite) begin
					port_mem[apb_req.paddr[3:0]] = apb_req.pwdata;
				end
				apb_rsp.pready <= 1'b0;
			end else begin
				wait_left--;
				apb_rsp.pready <= (wait_left == 0);
			end
		end
	end

	// ====================
	// Reference model
	// ====================
	function automatic logic [BITS-1:0] port_pattern(input int i);
		return 16'h5A00 ^ (i * 16'h0111);
	endfunction

	function automatic logic cond_true(input logic [2:0] cond, input cpu_flags_t f);
		logic [7:0] outcomes;
		outcomes = {f.s ^ f.v, f.v, f.s, !f.c, f.c, !f.z, f.z, 1'b1};
		return outcomes[cond];
	endfunction

	task automatic model_write(input logic [REGISTER_BITS-1:0] sel, input logic [BITS-1:0] v);
		if (sel != 0) begin
			reg_model[sel] = v;	// r0 stays zero.
		end
	endtask

	task automatic model_issue(input cpu_issue_t p);
		logic [3:0] op;
		logic       ctl;
		logic [3:0] d;
		int         w;
		apb_req_t   t;
		op = p.instr.ctl_fmt.opcode;
		ctl = p.instr.ctl_fmt.ctl_bit;
		d = p.instr.ctl_fmt.dest;
		w = (p.addr >> 1) % MEM_WORDS;
		t = '{psel: 1'b1, penable: 1'b0, pwrite: ctl, paddr: p.addr, pwdata: p.store_data};
		case (op)
			OP_ALU_SINGLE: model_write(p.instr.reg_fmt.src, p.alu_out);
			OP_ALU_REG, OP_ALU_IMM: model_write(p.instr.reg_fmt.dest, p.alu_out);
			OP_BRANCH: begin
				if (ctl) model_write(LINK_REGISTER, p.pc);
			end
			OP_BYTE_MEM: begin
				if (ctl && p.addr[0]) mem_model[w][7:0] = p.store_data[7:0];
				else if (ctl) mem_model[w][15:8] = p.store_data[7:0];
				else if (p.addr[0]) model_write(d, {8'h00, mem_model[w][7:0]});
				else model_write(d, {8'h00, mem_model[w][15:8]});
			end
			OP_WORD_MEM: begin
				if (ctl) mem_model[w] = p.store_data;
				else model_write(d, mem_model[w]);
			end
			OP_PEEK_POKE: begin
				expected.push_back(t);
				if (ctl) port_model[p.addr[3:0]] = p.store_data;
				else model_write(d, port_model[p.addr[3:0]]);
			end
			OP_INTERRUPT: model_write(INTERRUPT_LINK_REGISTER, p.pc);
			OP_COND_MOV: begin
				if (cond_true(p.instr.ctl_fmt.cond, p.flags)) model_write(d, p.alu_out);
			end
			default: ;
		endcase
	endtask

	// ====================
	// Stimulus helpers
	// ====================
	function automatic cpu_issue_t alu_pkt(input logic [3:0] op, input logic [3:0] dest,
			input logic [3:0] src, input logic [BITS-1:0] result);
		cpu_issue_t p;
		p = '0;
		p.valid = 1'b1;
		p.instr.reg_fmt.opcode = op;
		p.instr.reg_fmt.dest = dest;
		p.instr.reg_fmt.src = src;
		p.instr.reg_fmt.operand = 4'h9;
		p.alu_out = result;
		p.pc = 16'h0100;
		return p;
	endfunction

	function automatic cpu_issue_t ctl_pkt(input logic [3:0] op, input logic ctl,
			input logic [2:0] cond, input logic [3:0] dest, input logic [15:0] addr,
			input logic [BITS-1:0] data);
		cpu_issue_t p;
		p = '0;
		p.valid = 1'b1;
		p.instr.ctl_fmt.opcode = op;
		p.instr.ctl_fmt.ctl_bit = ctl;
		p.instr.ctl_fmt.cond = cond;
		p.instr.ctl_fmt.dest = dest;
		p.addr = addr;
		p.store_data = data;
		p.alu_out = data;
		p.pc = addr + 16'd2;
		return p;
	endfunction

	// Starts and ends just after a rising edge; returns on the accepting edge.
	task automatic send(input cpu_issue_t p);
		logic rdy;
		model_issue(p);
		issue <= p;
		do begin
			@(negedge clk);
			rdy = issue_ready;
			@(posedge clk);
		end while (!rdy);
		issue <= '0;
	endtask

	task automatic drain();
		logic rdy;
		do begin
			@(negedge clk);
			rdy = issue_ready;	// High again once any APB transfer has completed.
			@(posedge clk);
		end while (!rdy);
		@(posedge clk);	// Writeback edge of the last item.
	endtask

	task automatic read_pair(input logic [3:0] sa, input logic [3:0] sb);
		rd_sel_a <= sa;
		rd_sel_b <= sb;
		@(negedge clk);
		check_reg(sa, rd_data_a, reg_model[sa]);
		check_reg(sb, rd_data_b, reg_model[sb]);
		@(posedge clk);
	endtask

	task automatic sweep_registers();
		for (int i = 0; i < 16; i += 2) begin
			read_pair(i[3:0], 4'(i + 1));
		end
	endtask

	task automatic verify_transfers();
		while (expected.size() > 0) begin
			if (captured.size() == 0) begin
				errors++;
				$display("An expected APB transfer never started, %0t", $time);
				void'(expected.pop_front());
			end else begin
				check_apb(captured.pop_front(), expected.pop_front(), "setup");
			end
		end
		if (captured.size() > 0) begin
			errors++;
			$display("The DUT started %0d APB transfers that were not issued", captured.size());
			captured.delete();
		end
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic alu_writeback();
		send(alu_pkt(OP_ALU_SINGLE, 4'd3, 4'd5, 16'h1234));
		drain();
		read_pair(4'd5, 4'd3);
		send(alu_pkt(OP_ALU_REG, 4'd6, 4'd2, 16'hBEEF));
		send(alu_pkt(OP_ALU_IMM, 4'd7, 4'd6, 16'h00A5));	// Back to back.
		send(alu_pkt(OP_ALU_REG, 4'd0, 4'd7, 16'hFFFF));
		send(alu_pkt(OP_ALU_SINGLE, 4'd7, 4'd0, 16'h7777));
		drain();
		sweep_registers();
	endtask

	task automatic memory_access();
		send(ctl_pkt(OP_WORD_MEM, 1'b1, 3'd0, 4'd0, 16'h0010, 16'hA1B2));
		send(ctl_pkt(OP_BYTE_MEM, 1'b0, 3'd0, 4'd1, 16'h0010, 16'h0000));
		send(ctl_pkt(OP_BYTE_MEM, 1'b0, 3'd0, 4'd2, 16'h0011, 16'h0000));
		send(ctl_pkt(OP_WORD_MEM, 1'b0, 3'd0, 4'd3, 16'h0010, 16'h0000));
		send(ctl_pkt(OP_BYTE_MEM, 1'b1, 3'd0, 4'd0, 16'h0011, 16'h77CC));
		send(ctl_pkt(OP_WORD_MEM, 1'b0, 3'd0, 4'd4, 16'h0010, 16'h0000));
		send(ctl_pkt(OP_WORD_MEM, 1'b1, 3'd0, 4'd0, 16'h0020, 16'h1357));
		send(ctl_pkt(OP_BYTE_MEM, 1'b1, 3'd0, 4'd0, 16'h0020, 16'h00E6));
		send(ctl_pkt(OP_WORD_MEM, 1'b0, 3'd0, 4'd8, 16'h0020, 16'h0000));
		send(ctl_pkt(OP_BYTE_MEM, 1'b0, 3'd0, 4'd9, 16'h0021, 16'h0000));
		// Word index wraps at the RAM depth.
		send(ctl_pkt(OP_WORD_MEM, 1'b0, 3'd0, 4'd10, 16'(MEM_WORDS * 2 + 16'h10), 16'h0000));
		drain();
		sweep_registers();
	endtask

	task automatic link_writes();
		send(ctl_pkt(OP_BRANCH, 1'b1, 3'd0, 4'd0, 16'h0420, 16'h0000));
		drain();
		read_pair(LINK_REGISTER, INTERRUPT_LINK_REGISTER);
		send(ctl_pkt(OP_BRANCH, 1'b0, 3'd0, 4'd0, 16'h0555, 16'h0000));
		send(ctl_pkt(OP_INTERRUPT, 1'b0, 3'd0, 4'd0, 16'h0777, 16'h0000));
		drain();
		sweep_registers();
	endtask

	task automatic conditional_moves();
		cpu_issue_t p;
		cpu_flags_t f;
		logic       got_true;
		logic       got_false;
		for (int c = 0; c < 8; c++) begin
			got_true = 1'b0;
			got_false = 1'b0;
			for (int k = 0; k < 16; k++) begin
				f = cpu_flags_t'(k);
				if (cond_true(c[2:0], f) ? !got_true : !got_false) begin
					p = ctl_pkt(OP_COND_MOV, 1'b0, c[2:0], 4'd9, 16'h0, 16'(16'h3000 + c * 16 + k));
					p.flags = f;
					send(p);
					drain();
					read_pair(4'd9, 4'd8);
					if (cond_true(c[2:0], f)) got_true = 1'b1;
					else got_false = 1'b1;
				end
			end
		end
	endtask

	task automatic port_transfers();
		send(ctl_pkt(OP_PEEK_POKE, 1'b1, 3'd0, 4'd0, 16'h0003, 16'hC0DE));
		send(ctl_pkt(OP_PEEK_POKE, 1'b1, 3'd0, 4'd0, 16'h0009, 16'h1111));
		send(ctl_pkt(OP_PEEK_POKE, 1'b0, 3'd0, 4'd5, 16'h0003, 16'h0000));
		send(ctl_pkt(OP_PEEK_POKE, 1'b0, 3'd0, 4'd6, 16'h000C, 16'h0000));
		drain();
		read_pair(4'd5, 4'd6);
		// Items behind a pending transfer must wait and keep their order.
		send(ctl_pkt(OP_PEEK_POKE, 1'b0, 3'd0, 4'd11, 16'h0007, 16'h0000));
		send(alu_pkt(OP_ALU_REG, 4'd11, 4'd1, 16'h4242));
		send(ctl_pkt(OP_PEEK_POKE, 1'b1, 3'd0, 4'd0, 16'h0007, 16'h9ABC));
		send(ctl_pkt(OP_PEEK_POKE, 1'b0, 3'd0, 4'd13, 16'h0007, 16'h0000));
		send(alu_pkt(OP_ALU_IMM, 4'd12, 4'd1, 16'h0E0E));
		drain();
		sweep_registers();
		verify_transfers();
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		issue = '0;
		rd_sel_a = '0;
		rd_sel_b = '0;
		rst = 1'b1;
		for (int i = 0; i < 16; i++) begin
			reg_model[i] = '0;
			port_model[i] = port_pattern(i);
			port_mem[i] = port_pattern(i);
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (!issue_ready || apb_req.psel || apb_req.penable) begin
			errors++;
			$display("Handshake or APB outputs are not idle after reset, %0t", $time);
		end
		@(posedge clk);
		sweep_registers();
		alu_writeback();
		memory_access();
		link_writes();
		conditional_moves();
		port_transfers();
		$display("All tests done, %0d errors", errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hdl/cpu_pkg.sv
hdl/cpu_data_ram.sv
hdl/cpu_mem_stage.sv
hdl/cpu_writeback.sv
hdl/cpu_register_file.sv
hdl/cpu_backend_top.sv
dv/tb_cpu_backend.sv
